// ==== logic/debug_pkg.sv ====
package debug_pkg;

	localparam int data_bits = 32;
	localparam int gpr_count = 16;
	localparam int mem_words = 256;
	localparam int reset_cycles = 255; // target reset pulse length
	localparam int mem_latency = 2; // access to completion

	typedef enum logic [3:0] {
		cmd_halt = 4'h0,
		cmd_run = 4'h1,
		cmd_step = 4'h2,
		cmd_read_reg = 4'h3,
		cmd_write_reg = 4'h4,
		cmd_rmem32 = 4'h5,
		cmd_rmem16 = 4'h6,
		cmd_rmem8 = 4'h7,
		cmd_wmem32 = 4'h8,
		cmd_wmem16 = 4'h9,
		cmd_wmem8 = 4'ha,
		cmd_reset = 4'hb
	} cmd_t;

	typedef enum logic [1:0] {
		width_byte = 2'd0,
		width_half = 2'd1,
		width_word = 2'd2
	} width_t;

	typedef enum logic [1:0] {
		mbox_cmd = 2'd0,
		mbox_addr = 2'd1,
		mbox_data = 2'd2,
		mbox_result = 2'd3
	} mbox_addr_t;

	typedef struct packed {
		logic [data_bits-1:0] addr;
		width_t width;
		logic wr_en;
		logic [data_bits-1:0] wr_data;
	} mem_req_t;

	typedef struct packed {
		logic [$clog2(gpr_count)-1:0] sel;
		logic pc_sel; // address bit 4 picks the pc
		logic reg_wr_en;
		logic pc_wr_en;
		logic [data_bits-1:0] wr_val;
	} reg_req_t;

endpackage

// ==== logic/debug_mailbox.sv ====
`timescale 1ns/10ps

module debug_mailbox import debug_pkg::*; (
	input logic clk,
	input logic reset,
	input mbox_addr_t addr,
	input logic [31:0] din,
	input logic wr_en,
	output logic [31:0] dout,
	input mbox_addr_t ctl_addr,
	input logic [31:0] ctl_din,
	input logic ctl_wr_en,
	output logic [31:0] ctl_dout
);

	logic [data_bits-1:0] words [4];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) begin
				words[i] <= '0;
			end
		end else begin
			if (wr_en) begin
				words[addr] <= din;
			end
			if (ctl_wr_en) begin
				words[ctl_addr] <= ctl_din; // last assignment wins on a collision
			end
		end
	end

	assign dout = words[addr];
	assign ctl_dout = words[ctl_addr];

endmodule

// ==== logic/debug_controller.sv ====
`timescale 1ns/10ps

module debug_controller import debug_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	output mbox_addr_t ctl_addr,
	output logic [31:0] ctl_din,
	output logic ctl_wr_en,
	input logic [31:0] ctl_dout,
	output logic run,
	input logic stopped,
	output logic dbg_rst,
	input logic [31:0] pc,
	input logic [31:0] reg_val,
	output reg_req_t reg_req,
	output logic mem_access,
	output mem_req_t mem_req,
	input logic mem_compl,
	input logic [31:0] mem_rd_val
);

	typedef enum logic [3:0] {
		st_idle,
		st_load_cmd,
		st_load_addr,
		st_load_data,
		st_execute,
		st_wait_stopped,
		st_step,
		st_store_reg,
		st_write_reg,
		st_wait_mem,
		st_reset,
		st_compl
	} state_t;

	state_t state;
	state_t next_state;
	cmd_t debug_cmd;
	logic [data_bits-1:0] debug_addr;
	logic [data_bits-1:0] debug_data;
	logic [$clog2(reset_cycles)-1:0] reset_count;

	assign ack = state == st_compl;
	assign dbg_rst = state == st_reset;

	assign mem_req.addr = debug_addr;
	assign mem_req.wr_data = debug_data;
	assign reg_req.sel = debug_addr[$clog2(gpr_count)-1:0];
	assign reg_req.pc_sel = debug_addr[4];
	assign reg_req.wr_val = debug_data;

	always_comb begin
		mem_req.wr_en = 1'b0;
		case (debug_cmd)
		cmd_rmem16: mem_req.width = width_half;
		cmd_rmem8: mem_req.width = width_byte;
		cmd_wmem32: begin
			mem_req.width = width_word;
			mem_req.wr_en = 1'b1;
		end
		cmd_wmem16: begin
			mem_req.width = width_half;
			mem_req.wr_en = 1'b1;
		end
		cmd_wmem8: begin
			mem_req.width = width_byte;
			mem_req.wr_en = 1'b1;
		end
		default: mem_req.width = width_word;
		endcase
	end

	always_comb begin
		next_state = state;
		ctl_addr = mbox_cmd;
		ctl_din = '0;
		ctl_wr_en = 1'b0;
		mem_access = 1'b0;
		reg_req.reg_wr_en = 1'b0;
		reg_req.pc_wr_en = 1'b0;
		case (state)
		st_idle: if (req) next_state = st_load_cmd;
		st_load_cmd: next_state = st_load_addr;
		st_load_addr: begin
			ctl_addr = mbox_addr;
			next_state = st_load_data;
		end
		st_load_data: begin
			ctl_addr = mbox_data;
			next_state = st_execute;
		end
		st_execute: begin
			case (debug_cmd)
			cmd_halt: next_state = st_wait_stopped;
			cmd_step: next_state = st_step;
			cmd_read_reg: next_state = st_store_reg;
			cmd_write_reg: next_state = st_write_reg;
			cmd_rmem32, cmd_rmem16, cmd_rmem8, cmd_wmem32, cmd_wmem16, cmd_wmem8: begin
				mem_access = 1'b1;
				next_state = st_wait_mem;
			end
			cmd_reset: next_state = st_reset;
			default: next_state = st_compl; // run and unknown codes
			endcase
		end
		st_step: next_state = st_wait_stopped;
		st_wait_stopped: begin
			if (stopped) begin
				ctl_addr = mbox_result;
				ctl_din = pc;
				ctl_wr_en = 1'b1;
				next_state = st_compl;
			end
		end
		st_store_reg: begin
			ctl_addr = mbox_result;
			ctl_din = reg_val;
			ctl_wr_en = 1'b1;
			next_state = st_compl;
		end
		st_write_reg: begin
			reg_req.pc_wr_en = debug_addr[4];
			reg_req.reg_wr_en = ~debug_addr[4];
			next_state = st_compl;
		end
		st_wait_mem: begin
			if (mem_compl) begin
				if (!mem_req.wr_en) begin
					ctl_addr = mbox_result;
					ctl_din = mem_rd_val;
					ctl_wr_en = 1'b1;
				end
				next_state = st_compl;
			end
		end
		st_reset: if (reset_count == '0) next_state = st_compl;
		st_compl: if (!req) next_state = st_idle; // hold ack until the host drops req
		default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		case (state)
		st_load_cmd: debug_cmd <= cmd_t'(ctl_dout[3:0]);
		st_load_addr: debug_addr <= ctl_dout;
		st_load_data: debug_data <= ctl_dout;
		default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			run <= 1'b1;
			reset_count <= '0;
		end else begin
			state <= next_state;
			if (state == st_execute) begin
				reset_count <= $bits(reset_count)'(reset_cycles - 1);
				case (debug_cmd)
				cmd_halt, cmd_reset: run <= 1'b0;
				cmd_run, cmd_step: run <= 1'b1;
				default: ;
				endcase
			end
			if (state == st_step) begin
				run <= 1'b0; // one cycle of run per step
			end
			if (state == st_reset && reset_count != '0) begin
				reset_count <= reset_count - 1'b1;
			end
		end
	end

endmodule

// ==== logic/target_core.sv ====
`timescale 1ns/10ps

module target_core import debug_pkg::*; (
	input logic clk,
	input logic reset,
	input logic dbg_rst,
	input logic run,
	output logic stopped,
	input reg_req_t reg_req,
	output logic [31:0] reg_val,
	output logic [31:0] pc
);

	logic [data_bits-1:0] gpr [gpr_count];

	always_ff @(posedge clk) begin
		if (reset || dbg_rst) begin
			pc <= '0;
			for (int i = 0; i < gpr_count; i++) begin
				gpr[i] <= '0;
			end
		end else begin
			if (reg_req.pc_wr_en) begin
				pc <= reg_req.wr_val;
			end else if (run) begin
				pc <= pc + 'd4; // no execution, just fetch advance
			end
			if (reg_req.reg_wr_en) begin
				gpr[reg_req.sel] <= reg_req.wr_val;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stopped <= 1'b0; // run comes out of reset high
		end else begin
			stopped <= ~run;
		end
	end

	assign reg_val = reg_req.pc_sel ? pc : gpr[reg_req.sel];

endmodule

// ==== logic/target_memory.sv ====
`timescale 1ns/10ps

module target_memory import debug_pkg::*; (
	input logic clk,
	input logic reset,
	input logic mem_access,
	input mem_req_t mem_req,
	output logic mem_compl,
	output logic [31:0] rd_val
);

	localparam int lanes = data_bits / 8;

	logic [data_bits-1:0] mem [mem_words];
	logic [$clog2(mem_latency):0] count;
	logic busy;
	logic [$clog2(mem_words)-1:0] index;
	logic [1:0] offset;
	logic [data_bits-1:0] word;
	logic [lanes-1:0] byte_en;
	logic [data_bits-1:0] wr_lanes;

	assign index = mem_req.addr[2 +: $clog2(mem_words)];
	assign offset = mem_req.addr[1:0];
	assign word = mem[index];
	assign mem_compl = busy && count == '0;

	always_comb begin
		case (mem_req.width)
		width_byte: begin
			byte_en = lanes'(1) << offset;
			wr_lanes = {lanes{mem_req.wr_data[7:0]}};
			rd_val = {24'b0, word[8*offset +: 8]};
		end
		width_half: begin
			byte_en = lanes'(3) << {offset[1], 1'b0};
			wr_lanes = {(lanes / 2){mem_req.wr_data[15:0]}};
			rd_val = {16'b0, word[16*offset[1] +: 16]}; // little-endian halves
		end
		default: begin
			byte_en = '1;
			wr_lanes = mem_req.wr_data;
			rd_val = word;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (mem_access) begin
			busy <= 1'b1;
			count <= $bits(count)'(mem_latency - 1);
		end else if (mem_compl) begin
			busy <= 1'b0;
		end else if (busy) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_compl && mem_req.wr_en) begin
			for (int i = 0; i < lanes; i++) begin
				if (byte_en[i]) mem[index][8*i +: 8] <= wr_lanes[8*i +: 8];
			end
		end
	end

endmodule

// ==== logic/debug_top.sv ====
`timescale 1ns/10ps

module debug_top import debug_pkg::*; (
	input logic clk,
	input logic reset,
	input mbox_addr_t addr,
	input logic [31:0] din,
	input logic wr_en,
	output logic [31:0] dout,
	input logic req,
	output logic ack
);

	mbox_addr_t ctl_addr;
	logic [31:0] ctl_din;
	logic ctl_wr_en;
	logic [31:0] ctl_dout;
	logic run;
	logic stopped;
	logic dbg_rst;
	logic [31:0] pc;
	logic [31:0] reg_val;
	reg_req_t reg_req;
	logic mem_access;
	mem_req_t mem_req;
	logic mem_compl;
	logic [31:0] mem_rd_val;

	debug_mailbox debug_mailbox_inst (
		.clk(clk), .reset(reset),
		.addr(addr), .din(din), .wr_en(wr_en), .dout(dout),
		.ctl_addr(ctl_addr), .ctl_din(ctl_din), .ctl_wr_en(ctl_wr_en), .ctl_dout(ctl_dout)
	);

	debug_controller debug_controller_inst (
		.clk(clk), .reset(reset), .req(req), .ack(ack),
		.ctl_addr(ctl_addr), .ctl_din(ctl_din), .ctl_wr_en(ctl_wr_en), .ctl_dout(ctl_dout),
		.run(run), .stopped(stopped), .dbg_rst(dbg_rst), .pc(pc), .reg_val(reg_val),
		.reg_req(reg_req), .mem_access(mem_access), .mem_req(mem_req),
		.mem_compl(mem_compl), .mem_rd_val(mem_rd_val)
	);

	target_core target_core_inst (
		.clk(clk), .reset(reset), .dbg_rst(dbg_rst), .run(run), .stopped(stopped),
		.reg_req(reg_req), .reg_val(reg_val), .pc(pc)
	);

	target_memory target_memory_inst (
		.clk(clk), .reset(reset), .mem_access(mem_access), .mem_req(mem_req),
		.mem_compl(mem_compl), .rd_val(mem_rd_val)
	);

endmodule

// ==== verif/debug_tb.sv ====
`timescale 1ns/10ps

module debug_tb import debug_pkg::*; ();

	typedef enum logic [2:0] {
		chk_none,
		chk_exact,
		chk_saved,
		chk_plus4,
		chk_above_zero
	} check_t;

	typedef struct packed {
		cmd_t cmd;
		logic [31:0] addr;
		logic [31:0] data;
		check_t check;
		logic [31:0] expected;
	} row_t;

	localparam int row_count = 19;
	localparam int cycle_limit = row_count * 400 + 300;

	logic clk;
	logic reset;
	mbox_addr_t addr;
	logic [31:0] din;
	logic wr_en;
	logic [31:0] dout;
	logic req;
	logic ack;

	row_t rows[$];
	int errors;
	int cycles;
	logic [31:0] saved;
	logic [31:0] result;
	logic [31:0] reg_data;
	logic [31:0] pc_data;
	logic [31:0] mem_data;
	logic [31:0] byte_data;
	logic [31:0] half_data;
	logic [31:0] seed_ret;

	debug_top debug_top_inst (
		.clk(clk), .reset(reset), .addr(addr), .din(din), .wr_en(wr_en),
		.dout(dout), .req(req), .ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: no ack from the debug unit after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic add_row(input cmd_t c, input logic [31:0] a, input logic [31:0] d,
		input check_t k, input logic [31:0] e);
		row_t r;
		r = '{cmd: c, addr: a, data: d, check: k, expected: e};
		rows.push_back(r);
	endtask

	// one full mailbox transaction, returns the result word
	task automatic send_command(input row_t row, output logic [31:0] res);
		@(posedge clk);
		addr <= mbox_cmd;
		din <= {28'b0, row.cmd};
		wr_en <= 1'b1;
		@(posedge clk);
		addr <= mbox_addr;
		din <= row.addr;
		@(posedge clk);
		addr <= mbox_data;
		din <= row.data;
		@(posedge clk);
		wr_en <= 1'b0;
		req <= 1'b1;
		@(negedge clk);
		while (!ack) @(negedge clk);
		@(posedge clk);
		addr <= mbox_result;
		req <= 1'b0;
		@(negedge clk);
		res = dout;
		while (ack) @(negedge clk); // wait for the handshake to close
	endtask

	task automatic check_row(input int idx, input row_t row, input logic [31:0] res);
		logic [31:0] expected;
		int errors_before;
		errors_before = errors;
		case (row.check)
		chk_exact: expected = row.expected;
		chk_saved: expected = saved;
		chk_plus4: expected = saved + 32'd4;
		default: expected = '0;
		endcase
		if (row.check == chk_above_zero) begin
			assert (res != 32'd0) else begin
				$display("Error: dout 0x%08h, expected above 0x00000000", res);
				errors++;
			end
		end else if (row.check != chk_none) begin
			assert (res == expected) else begin
				$display("Error: dout 0x%08h, expected 0x%08h", res, expected);
				errors++;
			end
		end
		$display("row %0d cmd %0h addr %08h result %08h %s", idx, row.cmd, row.addr, res,
			(errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		reset = 1'b1;
		addr = mbox_cmd;
		din = '0;
		wr_en = 1'b0;
		req = 1'b0;
		errors = 0;
		cycles = 0;
		saved = '0;
		seed_ret = $urandom(32'h13b1);
		reg_data = $urandom();
		pc_data = $urandom();
		mem_data = $urandom();
		byte_data = $urandom();
		half_data = $urandom();

		add_row(cmd_halt, 32'h0, 32'h0, chk_none, 32'h0);
		add_row(cmd_halt, 32'h0, 32'h0, chk_saved, 32'h0); // halted pc holds
		add_row(cmd_step, 32'h0, 32'h0, chk_plus4, 32'h0);
		add_row(cmd_step, 32'h0, 32'h0, chk_plus4, 32'h0);
		add_row(cmd_write_reg, 32'h3, reg_data, chk_none, 32'h0);
		add_row(cmd_read_reg, 32'h3, 32'h0, chk_exact, reg_data);
		add_row(cmd_write_reg, 32'h10, pc_data, chk_none, 32'h0);
		add_row(cmd_read_reg, 32'h10, 32'h0, chk_exact, pc_data);
		add_row(cmd_wmem32, 32'h40, mem_data, chk_none, 32'h0);
		add_row(cmd_rmem32, 32'h40, 32'h0, chk_exact, mem_data);
		add_row(cmd_rmem16, 32'h42, 32'h0, chk_exact, {16'h0, mem_data[31:16]});
		add_row(cmd_rmem8, 32'h43, 32'h0, chk_exact, {24'h0, mem_data[31:24]});
		add_row(cmd_wmem8, 32'h41, byte_data, chk_none, 32'h0);
		add_row(cmd_wmem16, 32'h42, half_data, chk_none, 32'h0);
		add_row(cmd_rmem32, 32'h40, 32'h0, chk_exact,
			{half_data[15:0], byte_data[7:0], mem_data[7:0]});
		add_row(cmd_reset, 32'h0, 32'h0, chk_none, 32'h0);
		add_row(cmd_read_reg, 32'h10, 32'h0, chk_exact, 32'h0);
		add_row(cmd_run, 32'h0, 32'h0, chk_none, 32'h0);
		add_row(cmd_halt, 32'h0, 32'h0, chk_above_zero, 32'h0);

		repeat (10) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < rows.size(); i++) begin
			send_command(rows[i], result);
			check_row(i, rows[i], result);
			saved = result;
		end

		$display("%0d rows run, %0d errors", rows.size(), errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
logic/debug_pkg.sv
logic/debug_mailbox.sv
logic/debug_controller.sv
logic/target_core.sv
logic/target_memory.sv
logic/debug_top.sv
verif/debug_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sources.f --top-module debug_tb -o debug_sim

run: build
	./obj_dir/debug_sim | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module debug_tb

clean:
	rm -rf obj_dir $(LOG)
